/* Makefile */
SIM       ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= pcs_tx_tb
FILELIST  ?= pcs_tx_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, result taken from $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "sim passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/block_fetch.sv */
`timescale 1ns/1ps
`include "pcs_tx_params.svh"

module block_fetch (
   input  logic                      clk_in,
   input  logic                      reset,
   input  logic                      ena,
   input  logic                      rd_req,
   input  host_if_pkg::host_wr_t     host_wr,
   input  host_if_pkg::stream_cfg_t  stream_cfg,
   output pcs_block_pkg::block_t     fetch_block,
   output logic                      fetch_valid
);

   // Data stages after the registered address
   localparam int DATA_STAGES = `FETCH_LATENCY - 1;
   localparam int AW = host_if_pkg::BUF_ADDR_W;

   pcs_block_pkg::block_t        mem [`BUF_DEPTH];
   pcs_block_pkg::fetch_state_e  state;
   logic [AW-1:0]                rd_addr;
   logic [AW-1:0]                rd_addr_q;
   logic                         req_q;
   pcs_block_pkg::block_t        data_pipe [DATA_STAGES];
   logic [DATA_STAGES-1:0]       valid_pipe;

   // --------------------
   // Host write port
   // --------------------
   always_ff @(posedge clk_in) begin
      if (host_wr.wr_en) begin
         mem[host_wr.addr] <= host_wr.blk;
      end
   end

   // --------------------
   // FSM and address
   // --------------------
   // Idle holds address at 0 so every start reads entry 0 first
   always_ff @(posedge clk_in or posedge reset) begin
      if (reset) begin
         state   <= pcs_block_pkg::FETCH_IDLE;
         rd_addr <= '0;
         req_q   <= 1'b0;
      end else if (!ena) begin
         state   <= pcs_block_pkg::FETCH_IDLE;
         rd_addr <= '0;
         req_q   <= 1'b0;
      end else begin
         state <= pcs_block_pkg::FETCH_RUN;
         req_q <= rd_req && (state == pcs_block_pkg::FETCH_RUN);
         if (rd_req && (state == pcs_block_pkg::FETCH_RUN)) begin
            // Wrap after the last configured entry
            rd_addr <= (rd_addr == stream_cfg.blk_count) ? '0 : rd_addr + 1'b1;
         end
      end
   end

   // Capture the address of the accepted request
   always_ff @(posedge clk_in) begin
      if (rd_req) begin
         rd_addr_q <= rd_addr;
      end
   end

   // --------------------
   // Read data pipeline
   // --------------------
   always_ff @(posedge clk_in) begin
      data_pipe[0] <= mem[rd_addr_q];
      for (int i = 1; i < DATA_STAGES; i++) begin
         data_pipe[i] <= data_pipe[i-1];
      end
   end

   // Valid bit rides along with the data and clears when the stream stops
   always_ff @(posedge clk_in or posedge reset) begin
      if (reset) begin
         valid_pipe <= '0;
      end else if (!ena) begin
         valid_pipe <= '0;
      end else begin
         valid_pipe[0] <= req_q;
         for (int i = 1; i < DATA_STAGES; i++) begin
            valid_pipe[i] <= valid_pipe[i-1];
         end
      end
   end

   assign fetch_block = data_pipe[DATA_STAGES-1];
   assign fetch_valid = valid_pipe[DATA_STAGES-1];

endmodule

/* design/gearbox_66_40.sv */
`timescale 1ns/1ps
`include "pcs_tx_params.svh"

module gearbox_66_40 (
   input  logic                        clk_in,
   input  logic                        reset,
   input  logic                        ena,
   input  pcs_block_pkg::block_t       blk,
   output logic                        rd_req,
   output pcs_block_pkg::lane_word_t   data_out
);

   localparam int DLY = `GBX_READ_DELAY;

   // Phase tag that travels with each request
   typedef struct packed {
      logic        live;
      logic        req;
      logic [5:0]  phase;
   } gbx_tag_t;

   logic                   run;
   logic [5:0]             phase;
   gbx_tag_t               tag_q;
   gbx_tag_t               tag_pipe [DLY];
   gbx_tag_t               out_tag;
   pcs_block_pkg::block_t  sr0;
   pcs_block_pkg::block_t  sr1;
   logic [131:0]           window;

   // 20 blocks per 33 words, no new block needed in these phases
   function automatic logic req_pattern(input logic [5:0] ph);
      case (ph)
         6'd2, 6'd5, 6'd7, 6'd10, 6'd12, 6'd15, 6'd17,
         6'd20, 6'd22, 6'd25, 6'd27, 6'd30, 6'd32: req_pattern = 1'b0;
         default: req_pattern = 1'b1;
      endcase
   endfunction

   // Bit offset of the word inside {sr0, sr1}
   // Word p starts at stream bit 40p, sr0 holds the block with bit 40p+39
   function automatic logic [6:0] word_offset(input logic [5:0] ph);
      logic [11:0] bit_pos;
      logic [6:0]  rem;
      bit_pos = 12'(ph) * 12'd40;
      rem     = 7'(bit_pos % 12'd66);
      word_offset = (rem >= 7'd27) ? rem : rem + 7'd66;
   endfunction

   // --------------------
   // Phase and request
   // --------------------
   // One start cycle after ena rises, phase held at 0 until then
   always_ff @(posedge clk_in or posedge reset) begin
      if (reset) begin
         run   <= 1'b0;
         phase <= '0;
         tag_q <= '0;
      end else begin
         run         <= ena;
         tag_q.live  <= ena && run;
         tag_q.req   <= ena && run && req_pattern(phase);
         tag_q.phase <= phase;
         if (!ena || !run) begin
            phase <= '0;
         end else begin
            phase <= (phase == 6'd32) ? '0 : phase + 6'd1;
         end
      end
   end

   assign rd_req = tag_q.req;

   // Delay so each tag meets the block its request fetched
   always_ff @(posedge clk_in or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < DLY; i++) begin
            tag_pipe[i] <= '0;
         end
         out_tag <= '0;
      end else if (!ena) begin
         for (int i = 0; i < DLY; i++) begin
            tag_pipe[i] <= '0;
         end
         out_tag <= '0;
      end else begin
         tag_pipe[0] <= tag_q;
         for (int i = 1; i < DLY; i++) begin
            tag_pipe[i] <= tag_pipe[i-1];
         end
         out_tag <= tag_pipe[DLY-1];
      end
   end

   // --------------------
   // Block shift and slice
   // --------------------
   always_ff @(posedge clk_in) begin
      if (tag_pipe[DLY-1].req) begin
         sr0 <= blk;
         sr1 <= sr0;
      end
   end

   // Older block in the low half
   assign window = {sr0, sr1};

   always_ff @(posedge clk_in or posedge reset) begin
      if (reset) begin
         data_out <= '0;
      end else if (!ena || !out_tag.live) begin
         data_out <= '0;
      end else begin
         data_out <= window[word_offset(out_tag.phase) +: pcs_block_pkg::LANE_W];
      end
   end

endmodule

/* design/host_if_pkg.sv */
`include "pcs_tx_params.svh"

package host_if_pkg;

   // Buffer address width, 5 bits for 32 entries
   localparam int BUF_ADDR_W = $clog2(`BUF_DEPTH);

   // Host write into the block buffer
   typedef struct packed {
      logic                       wr_en;
      logic [BUF_ADDR_W-1:0]      addr;
      pcs_block_pkg::block_t      blk;
   } host_wr_t;

   // Static stream setup
   // blk_count is the last valid buffer index, so entries 0..blk_count are sent
   typedef struct packed {
      logic [BUF_ADDR_W-1:0]      blk_count;
      pcs_block_pkg::scr_mode_e   scr_mode;
   } stream_cfg_t;

endpackage

/* design/payload_scrambler.sv */
`timescale 1ns/1ps
`include "pcs_tx_params.svh"

module payload_scrambler (
   input  logic                      clk_in,
   input  logic                      reset,
   input  logic                      ena,
   input  pcs_block_pkg::scr_mode_e  scr_mode,
   input  pcs_block_pkg::block_t     in_block,
   input  logic                      in_valid,
   output pcs_block_pkg::block_t     out_block
);

   logic [57:0]  scr_state;
   logic [57:0]  scr_next;
   logic [63:0]  payload_scr;
   logic         scr_on;

   assign scr_on = (scr_mode == pcs_block_pkg::SCR_ON);

   // --------------------
   // x^58 + x^39 + 1
   // --------------------
   // Bit 0 first, each scrambled bit feeds back into the state
   // scr_next[38] is the bit 39 back, scr_next[57] the bit 58 back
   always_comb begin
      scr_next = scr_state;
      for (int i = 0; i < 64; i++) begin
         payload_scr[i] = in_block.payload[i] ^ scr_next[38] ^ scr_next[57];
         scr_next       = {scr_next[56:0], payload_scr[i]};
      end
   end

   // State only moves on real blocks, and restarts from seed when idle
   always_ff @(posedge clk_in or posedge reset) begin
      if (reset) begin
         scr_state <= `SCR_SEED;
      end else if (!ena) begin
         scr_state <= `SCR_SEED;
      end else if (in_valid && scr_on) begin
         scr_state <= scr_next;
      end
   end

   // Output stage
   // Sync header is never scrambled
   always_ff @(posedge clk_in) begin
      out_block.sync    <= in_block.sync;
      out_block.payload <= scr_on ? payload_scr : in_block.payload;
   end

endmodule

/* design/pcs_block_pkg.sv */
package pcs_block_pkg;

   // --------------------
   // Block level types
   // --------------------

   // Serializer word width
   localparam int LANE_W = 40;

   // 64b/66b sync header, 01 for data and 10 for control
   typedef logic [1:0] sync_hdr_t;

   // One encoded block
   // Sync header sits in bits 1:0, payload in bits 65:2
   typedef struct packed {
      logic [63:0] payload;
      sync_hdr_t   sync;
   } block_t;

   // One word toward the serializer, bit 0 goes out first
   typedef logic [LANE_W-1:0] lane_word_t;

   // Scrambler mode
   typedef enum logic {
      SCR_ON     = 1'b0,
      SCR_BYPASS = 1'b1
   } scr_mode_e;

   // Fetch stage FSM
   typedef enum logic {
      FETCH_IDLE = 1'b0,
      FETCH_RUN  = 1'b1
   } fetch_state_e;

endpackage

/* design/pcs_tx_params.svh */
`ifndef PCS_TX_PARAMS_SVH
`define PCS_TX_PARAMS_SVH

// Block buffer entries
`define BUF_DEPTH 32

// Cycles from read request to fetch output
`define FETCH_LATENCY 2

// Scrambler register stage
`define SCR_LATENCY 1

// Gearbox delay on phase and request, matches fetch plus scrambler
`define GBX_READ_DELAY (`FETCH_LATENCY + `SCR_LATENCY)

// Scrambler start state, all ones
`define SCR_SEED 58'h3ff_ffff_ffff_ffff

// First output word, counted from the first edge that sees ena high
`define FIRST_WORD_CYCLES (`GBX_READ_DELAY + 3)

`endif

/* design/pcs_tx_top.sv */
`timescale 1ns/1ps

module pcs_tx_top (
   input  logic                        clk_in,
   input  logic                        reset,
   input  logic                        ena,
   input  host_if_pkg::host_wr_t       host_wr,
   input  host_if_pkg::stream_cfg_t    stream_cfg,
   output pcs_block_pkg::lane_word_t   data_out
);

   // Stage links
   logic                   rd_req;
   pcs_block_pkg::block_t  fetch_block;
   logic                   fetch_valid;
   pcs_block_pkg::block_t  scr_block;

   // Buffer read, fixed latency
   block_fetch u_fetch (
      .clk_in      (clk_in),
      .reset       (reset),
      .ena         (ena),
      .rd_req      (rd_req),
      .host_wr     (host_wr),
      .stream_cfg  (stream_cfg),
      .fetch_block (fetch_block),
      .fetch_valid (fetch_valid)
   );

   payload_scrambler u_scr (
      .clk_in    (clk_in),
      .reset     (reset),
      .ena       (ena),
      .scr_mode  (stream_cfg.scr_mode),
      .in_block  (fetch_block),
      .in_valid  (fetch_valid),
      .out_block (scr_block)
   );

   // Issues the reads, consumes the scrambled blocks
   gearbox_66_40 u_gbx (
      .clk_in   (clk_in),
      .reset    (reset),
      .ena      (ena),
      .blk      (scr_block),
      .rd_req   (rd_req),
      .data_out (data_out)
   );

endmodule

/* pcs_tx_top.f */
+incdir+design
design/pcs_block_pkg.sv
design/host_if_pkg.sv
design/block_fetch.sv
design/payload_scrambler.sv
design/gearbox_66_40.sv
design/pcs_tx_top.sv
tests/pcs_tx_tb.sv

/* tests/pcs_tx_golden.hex */
// Entries 0-19: raw 66-bit blocks {payload, sync}, block 0 first
// Entries 20-52: expected 40-bit words with the scrambler on, word 0 first
00FFFFE0000000001
3F00001FFFFFFFFFE
3FFFFFFFFFFFFFFFD
00FFFFE0000000001
3F00001FFFFFFFFFE
00FFFFE0000000002
00000000000000001
3F00001FFFFFFFFFD
00FFFFE0000000002
3F00001FFFFFFFFFD
3FFFFFFFFFFFFFFFE
00FFFFE0000000001
3F00001FFFFFFFFFD
3FFFFFFFFFFFFFFFE
00FFFFE0000000001
00000000000000002
3F00001FFFFFFFFFD
00FFFFE0000000001
3F00001FFFFFFFFFE
00FFFFE0000000001
0000000001
FFF8000000
FFFFFFFFFF
FFFFFFDFFF
7FFFFFFFFF
0000000000
FFFE000000
FFFFFFFFFF
0000000BFF
1000000000
0000000000
FFFF400000
FFFFFFFFFF
00000002FF
F400000000
FFFFFFFFFF
FFFFEFFFFF
FFFFFFFFFF
000000007F
FD00000000
FFFFFFFFFF
FFFFFBFFFF
FFFFFFFFFF
000000001F
0080000000
0000000000
FFFFFD0000
FFFFFFFFFF
0000000007
FFE0000000
FFFFFFFFFF
0000007FFF
0000000000

/* tests/pcs_tx_tb.sv */
`timescale 1ns/1ps
`include "pcs_tx_params.svh"

module pcs_tx_tb;

   localparam int N_BLOCKS = 20;
   localparam int N_WORDS = 33;
   localparam int RESET_CYCLES = 8;
   localparam int N_RUNS = 4;
   localparam int CLK_PERIOD = 10;
   // Each run gets its idle gap, start latency and one gearbox period
   localparam int WATCHDOG_CYCLES =
      RESET_CYCLES + N_RUNS * (N_WORDS + `FIRST_WORD_CYCLES + 16);

   logic                        clk_in;
   logic                        reset;
   logic                        ena;
   host_if_pkg::host_wr_t       host_wr;
   host_if_pkg::stream_cfg_t    stream_cfg;
   pcs_block_pkg::lane_word_t   data_out;

   // Each golden entry holds one 17 digit line in 68 bits
   logic [67:0]                 golden_mem [N_BLOCKS + N_WORDS];
   pcs_block_pkg::block_t       raw_blocks [N_BLOCKS];
   pcs_block_pkg::lane_word_t   exp_words [N_WORDS];
   integer                      seed;

   pcs_tx_top u_dut (
      .clk_in     (clk_in),
      .reset      (reset),
      .ena        (ena),
      .host_wr    (host_wr),
      .stream_cfg (stream_cfg),
      .data_out   (data_out)
   );

   initial clk_in = 1'b0;
   always #(CLK_PERIOD / 2) clk_in = ~clk_in;

   // --------------------
   // Checks
   // --------------------
   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1, "stopping at first failure");
   endtask

   task automatic check_word(input string what, input pcs_block_pkg::lane_word_t got,
                             input pcs_block_pkg::lane_word_t exp);
      if (got !== exp) begin
         report_failure($sformatf("error data_out %s got %h exp %h", what, got, exp));
      end
   endtask

   // Block cut back out of the captured word stream
   task automatic check_block(input int idx, input pcs_block_pkg::block_t got,
                              input pcs_block_pkg::block_t exp);
      if (got !== exp) begin
         report_failure($sformatf("error data_out block %0d got %h exp %h", idx, got, exp));
      end
   endtask

   // --------------------
   // Stimulus
   // --------------------
   task automatic load_golden();
      $readmemh("tests/pcs_tx_golden.hex", golden_mem);
      for (int i = 0; i < N_BLOCKS; i++) begin
         raw_blocks[i] = golden_mem[i][65:0];
         // A real block never has sync 00
         if ($isunknown(golden_mem[i]) || raw_blocks[i].sync == 2'b00) begin
            report_failure("golden file is missing or holds an invalid block");
         end
      end
      for (int k = 0; k < N_WORDS; k++) begin
         exp_words[k] = golden_mem[N_BLOCKS + k][39:0];
      end
   endtask

   // Fill the buffer while the stream is stopped and output stays zero
   task automatic write_blocks();
      for (int i = 0; i < N_BLOCKS; i++) begin
         host_wr.wr_en = 1'b1;
         host_wr.addr  = i[host_if_pkg::BUF_ADDR_W-1:0];
         host_wr.blk   = raw_blocks[i];
         @(negedge clk_in);
         check_word("idle", data_out, '0);
      end
      host_wr = '0;
   endtask

   // One stream start after a random idle gap with 33 words captured
   task automatic run_stream(input pcs_block_pkg::scr_mode_e mode, input logic [4:0] count);
      int                    gap;
      logic [N_WORDS*40-1:0] stream_bits;
      gap = 1 + int'($unsigned($random(seed)) % 8);
      stream_cfg.blk_count = count;
      stream_cfg.scr_mode  = mode;
      repeat (gap) begin
         @(negedge clk_in);
         check_word("idle", data_out, '0);
      end
      ena = 1'b1;
      // Nothing comes out before the first word
      repeat (`FIRST_WORD_CYCLES) begin
         @(negedge clk_in);
         check_word("latency", data_out, '0);
      end
      for (int k = 0; k < N_WORDS; k++) begin
         @(negedge clk_in);
         stream_bits[k*40 +: 40] = data_out;
         if (mode == pcs_block_pkg::SCR_ON) begin
            check_word($sformatf("word %0d", k), data_out, exp_words[k]);
         end
      end
      ena = 1'b0;
      // Bypass blocks sit at stream bit 66b and repeat after count
      if (mode == pcs_block_pkg::SCR_BYPASS) begin
         for (int b = 0; b < N_BLOCKS; b++) begin
            check_block(b, stream_bits[66*b +: 66], raw_blocks[b % (count + 1)]);
         end
      end
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      report_failure("timeout, the stream runs did not finish within the watchdog limit");
   end

   initial begin
      seed       = 32'hd627_6bfe;
      reset      = 1'b1;
      ena        = 1'b0;
      host_wr    = '0;
      stream_cfg = '0;
      load_golden();
      repeat (RESET_CYCLES) @(negedge clk_in);
      reset = 1'b0;
      write_blocks();
      // Scrambled, then again after a gap, then raw, then raw with wrap at 9
      run_stream(pcs_block_pkg::SCR_ON, 5'd19);
      run_stream(pcs_block_pkg::SCR_ON, 5'd19);
      run_stream(pcs_block_pkg::SCR_BYPASS, 5'd19);
      run_stream(pcs_block_pkg::SCR_BYPASS, 5'd9);
      $display("sim passed");
      $finish;
   end

endmodule
